//--- sdr_rx_settings.svh
//////////////////////////////////////////////////
// build-time knobs for the rx sample path
// decimation must be a power of two (given as log2)
//////////////////////////////////////////////////
`ifndef SDR_RX_SETTINGS_SVH
`define SDR_RX_SETTINGS_SVH

// adc channels and matching lanes
// adc_capture only has the da/db buses, keep at 2
`define SDR_NUM_CH 2

// log2 of the averaging factor
`define SDR_DECIM_LOG2 2

// downstream buffer depth, in credits
// the packer starts out holding all of them
`define SDR_CREDITS 4

// sys0_clk cycles per sclk half period
// one full sclk bit takes twice this
`define SDR_SPI_DIV 2

`endif

//--- sdr_rx_pkg.sv
//////////////////////////////////////////////////
// shared types for the rx path and adc spi port
//////////////////////////////////////////////////
`include "sdr_rx_settings.svh"

package sdr_rx_pkg;

  // channel tag width, never below one bit
  localparam int CH_W = (`SDR_NUM_CH > 1) ? $clog2(`SDR_NUM_CH) : 1;

  typedef logic signed [13:0] adc_word_t;  // two's complement adc sample

  // capture output, one word per channel
  typedef struct packed {
    logic                              valid;
    adc_word_t [`SDR_NUM_CH-1:0]       ch;
  } ch_samples_t;

  // lane holding register contents
  typedef struct packed {
    logic      valid;
    adc_word_t sample;  // averaged value
  } lane_out_t;

  // output stream word, 23 bits with two channels
  typedef struct packed {
    logic [CH_W-1:0] ch;      // source lane
    logic [7:0]      seq;     // wraps at 256
    adc_word_t       sample;
  } stream_word_t;

  // frame's leading r/w bit
  typedef enum logic {
    SPI_WRITE = 1'b0,
    SPI_READ  = 1'b1
  } spi_op_e;

  typedef struct packed {
    spi_op_e    op;
    logic [7:0] addr;  // only [6:0] goes on the wire
    logic [7:0] data;  // ignored for reads
  } spi_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } spi_state_e;

endpackage

//--- adc_capture.sv
//////////////////////////////////////////////////
// adc buses arrive as offset binary on sys0_clk
// no deskew or clock crossing here
//////////////////////////////////////////////////
`timescale 1ns/1ps

module adc_capture (
  input  logic                    sys0_clk,
  input  logic                    rst_i,
  input  logic                    capture_en_i,  // sample this cycle
  input  logic [13:0]             adc_da_i,      // channel 0, offset binary
  input  logic [13:0]             adc_db_i,      // channel 1, offset binary
  output sdr_rx_pkg::ch_samples_t samples_o
);

  logic                  valid_q;
  sdr_rx_pkg::adc_word_t da_q;
  sdr_rx_pkg::adc_word_t db_q;

  // offset binary to two's complement
  // midscale 0x2000 lands on zero
  function automatic sdr_rx_pkg::adc_word_t ob_to_tc(input logic [13:0] raw);
    return sdr_rx_pkg::adc_word_t'({~raw[13], raw[12:0]});
  endfunction

  // valid tracks the enable one cycle late
  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= capture_en_i;
    end
  end

  // sample words, held while capture is off
  always_ff @(posedge sys0_clk) begin
    if (capture_en_i) begin
      da_q <= ob_to_tc(adc_da_i);
      db_q <= ob_to_tc(adc_db_i);
    end
  end

  always_comb begin
    samples_o       = '0;       // spare channels, if any, read zero
    samples_o.valid = valid_q;
    samples_o.ch[0] = da_q;
    samples_o.ch[1] = db_q;
  end

endmodule

//--- rx_lane.sv
//////////////////////////////////////////////////
// one holding slot per lane, extra averages lost
// overflow stays set until rst_i
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sdr_rx_settings.svh"

module rx_lane (
  input  logic                  sys0_clk,
  input  logic                  rst_i,
  input  logic                  in_valid_i,   // capture valid
  input  sdr_rx_pkg::adc_word_t in_sample_i,
  input  logic                  take_i,       // packer drains the slot
  output sdr_rx_pkg::lane_out_t out_o,
  output logic                  overflow_o    // sticky drop flag
);

  localparam int LOG2  = `SDR_DECIM_LOG2;
  localparam int ACC_W = $bits(sdr_rx_pkg::adc_word_t) + LOG2;  // 16 at decim 4

  logic signed [ACC_W-1:0] acc_q;       // running sum of the block
  logic signed [ACC_W-1:0] sample_ext;  // sign extended input
  logic signed [ACC_W-1:0] acc_next;
  logic [LOG2-1:0]         dec_cnt_q;   // samples seen in block
  logic                    first_sample;
  logic                    last_sample;
  logic                    load;
  logic                    drop;
  sdr_rx_pkg::adc_word_t   avg;
  logic                    hold_valid_q;
  sdr_rx_pkg::adc_word_t   hold_sample_q;
  logic                    ovf_q;

  assign sample_ext = {{LOG2{in_sample_i[13]}}, in_sample_i};

  assign first_sample = (dec_cnt_q == '0);
  assign last_sample  = in_valid_i && (dec_cnt_q == '1);

  // first sample reloads, so acc needs no clearing
  assign acc_next = first_sample ? sample_ext : acc_q + sample_ext;

  // arithmetic shift floors toward minus infinity
  assign avg = sdr_rx_pkg::adc_word_t'(acc_next >>> LOG2);

  // slot free, or emptied this same cycle
  assign load = last_sample && (!hold_valid_q || take_i);
  assign drop = last_sample && hold_valid_q && !take_i;

  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      dec_cnt_q    <= '0;
      hold_valid_q <= 1'b0;
      ovf_q        <= 1'b0;
    end else begin
      if (in_valid_i) begin
        dec_cnt_q <= dec_cnt_q + 1'b1;  // wraps at block end
      end
      if (load) begin
        hold_valid_q <= 1'b1;
      end else if (take_i) begin
        hold_valid_q <= 1'b0;
      end
      if (drop) begin
        ovf_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys0_clk) begin
    if (in_valid_i) begin
      acc_q <= acc_next;
    end
    if (load) begin
      hold_sample_q <= avg;
    end
  end

  assign out_o.valid  = hold_valid_q;
  assign out_o.sample = hold_sample_q;
  assign overflow_o   = ovf_q;

endmodule

//--- sample_packer.sv
//////////////////////////////////////////////////
// at most one word per cycle, and only with credit
// credit_i returns one credit per high cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sdr_rx_settings.svh"

module sample_packer (
  input  logic                                   sys0_clk,
  input  logic                                   rst_i,
  input  sdr_rx_pkg::lane_out_t [`SDR_NUM_CH-1:0] lanes_i,
  output logic [`SDR_NUM_CH-1:0]                 take_o,   // one hot or zero
  input  logic                                   credit_i,
  output logic                                   stream_valid_o,
  output sdr_rx_pkg::stream_word_t               stream_o
);

  localparam int NCH  = `SDR_NUM_CH;
  localparam int CH_W = sdr_rx_pkg::CH_W;
  localparam int CR_W = $clog2(`SDR_CREDITS + 1);

  logic [CH_W-1:0] rr_ptr_q;     // first lane to look at
  logic [CH_W-1:0] grant_idx;
  logic [CH_W:0]   probe;        // one spare bit for the wrap
  logic            grant_found;
  logic            send;
  logic [CR_W-1:0] credit_q;
  logic [7:0]      seq_q;

  // scan from the pointer, skipping empty lanes
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = rr_ptr_q;
    probe       = '0;
    for (int i = 0; i < NCH; i++) begin
      probe = {1'b0, rr_ptr_q} + (CH_W+1)'(i);
      if (probe >= NCH) begin
        probe = probe - (CH_W+1)'(NCH);
      end
      if (!grant_found && lanes_i[probe[CH_W-1:0]].valid) begin
        grant_found = 1'b1;
        grant_idx   = probe[CH_W-1:0];
      end
    end
  end

  assign send = grant_found && (credit_q != '0);  // nothing goes out at zero credit

  always_comb begin
    take_o = '0;
    if (send) begin
      take_o[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      rr_ptr_q       <= '0;
      credit_q       <= CR_W'(`SDR_CREDITS);  // downstream buffer starts empty
      seq_q          <= '0;
      stream_valid_o <= 1'b0;
    end else begin
      stream_valid_o <= send;
      if (send) begin
        seq_q    <= seq_q + 1'b1;
        rr_ptr_q <= (grant_idx == CH_W'(NCH-1)) ? '0 : grant_idx + 1'b1;
      end
      case ({send, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;  // spend and return cancel
      endcase
    end
  end

  // word registered in the take cycle
  always_ff @(posedge sys0_clk) begin
    if (send) begin
      stream_o.ch     <= grant_idx;
      stream_o.seq    <= seq_q;
      stream_o.sample <= lanes_i[grant_idx].sample;
    end
  end

endmodule

//--- adc_spi_ctrl.sv
//////////////////////////////////////////////////
// 16 bit frames, r/w + 7b addr + 8b data, msb first
// board sclk idles high once gated outside
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sdr_rx_settings.svh"

module adc_spi_ctrl (
  input  logic                 sys0_clk,
  input  logic                 rst_i,
  input  logic                 cmd_valid_i,
  input  sdr_rx_pkg::spi_cmd_t cmd_i,
  output logic                 cmd_ready_o,
  output logic                 rd_valid_o,   // one cycle, reads only
  output logic [7:0]           rd_data_o,
  output logic                 sclk_drv_o,   // raw clock, idles low
  output logic                 sclk_gate_o,
  output logic                 sen_o,        // active low enable
  output logic                 mosi_o,
  input  logic                 miso_i
);

  localparam int DIV   = `SDR_SPI_DIV;
  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

  sdr_rx_pkg::spi_state_e state_q;
  sdr_rx_pkg::spi_op_e    op_q;
  logic [DIV_W-1:0]       div_q;      // half period timer
  logic [3:0]             bit_q;      // falling edges so far
  logic [15:0]            tx_q;
  logic [7:0]             rx_q;       // last eight miso bits
  logic                   sclk_q;
  logic                   accept;
  logic                   half_tick;
  logic                   rise;
  logic                   fall;

  assign accept    = cmd_valid_i && cmd_ready_o;
  assign half_tick = (state_q == sdr_rx_pkg::SHIFT) && (div_q == DIV_W'(DIV-1));
  assign rise      = half_tick && !sclk_q;  // slave data sampled here
  assign fall      = half_tick && sclk_q;   // next mosi bit here

  always_ff @(posedge sys0_clk) begin
    if (rst_i) begin
      state_q <= sdr_rx_pkg::IDLE;
      op_q    <= sdr_rx_pkg::SPI_WRITE;
      div_q   <= '0;
      bit_q   <= '0;
      sclk_q  <= 1'b0;
    end else begin
      case (state_q)
        sdr_rx_pkg::IDLE: begin
          if (accept) begin
            state_q <= sdr_rx_pkg::SHIFT;
            op_q    <= cmd_i.op;
            div_q   <= '0;
            bit_q   <= '0;
          end
        end
        sdr_rx_pkg::SHIFT: begin
          div_q <= half_tick ? '0 : div_q + 1'b1;
          if (half_tick) begin
            sclk_q <= !sclk_q;
          end
          if (fall) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 4'd15) begin
              state_q <= sdr_rx_pkg::DONE;  // sclk back low too
            end
          end
        end
        sdr_rx_pkg::DONE: state_q <= sdr_rx_pkg::IDLE;
        default:          state_q <= sdr_rx_pkg::IDLE;
      endcase
    end
  end

  // frame shifter, addr bit 7 is not sent
  always_ff @(posedge sys0_clk) begin
    if (accept) begin
      tx_q <= {cmd_i.op == sdr_rx_pkg::SPI_READ, cmd_i.addr[6:0], cmd_i.data};
    end else if (fall) begin
      tx_q <= {tx_q[14:0], 1'b0};
    end
    if (rise) begin
      rx_q <= {rx_q[6:0], miso_i};
    end
  end

  assign cmd_ready_o = (state_q == sdr_rx_pkg::IDLE);
  assign sen_o       = (state_q == sdr_rx_pkg::IDLE);   // low through SHIFT and DONE
  assign sclk_gate_o = (state_q == sdr_rx_pkg::SHIFT);
  assign sclk_drv_o  = sclk_q;
  assign mosi_o      = (state_q == sdr_rx_pkg::SHIFT) ? tx_q[15] : 1'b0;
  assign rd_valid_o  = (state_q == sdr_rx_pkg::DONE) && (op_q == sdr_rx_pkg::SPI_READ);
  assign rd_data_o   = rx_q;

endmodule

//--- sdr_rx_top.sv
//////////////////////////////////////////////////
// single clock, sys0_clk stands in for adc_clkout
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sdr_rx_settings.svh"

module sdr_rx_top (
  input  logic                     sys0_clk,
  input  logic                     rst_i,
  input  logic                     capture_en_i,
  input  logic [13:0]              adc_da_i,
  input  logic [13:0]              adc_db_i,
  input  logic                     credit_i,       // one credit per high cycle
  output logic                     stream_valid_o,
  output sdr_rx_pkg::stream_word_t stream_o,
  output logic [`SDR_NUM_CH-1:0]   overflow_o,     // per lane, sticky
  input  logic                     cmd_valid_i,
  input  sdr_rx_pkg::spi_cmd_t     cmd_i,
  output logic                     cmd_ready_o,
  output logic                     rd_valid_o,
  output logic [7:0]               rd_data_o,
  output logic                     adc_sclk_o,
  output logic                     adc_sen_o,
  output logic                     adc_smosi_o,
  input  logic                     adc_smiso_i
);

  sdr_rx_pkg::ch_samples_t                samples;
  sdr_rx_pkg::lane_out_t [`SDR_NUM_CH-1:0] lane_out;
  logic [`SDR_NUM_CH-1:0]                 lane_take;
  logic                                   sclk_drv;
  logic                                   sclk_gate;
  logic                                   sen;

  adc_capture i_adc_capture (
    .sys0_clk     (sys0_clk),
    .rst_i        (rst_i),
    .capture_en_i (capture_en_i),
    .adc_da_i     (adc_da_i),
    .adc_db_i     (adc_db_i),
    .samples_o    (samples)
  );

  // one decimating lane per adc channel
  generate
    for (genvar g = 0; g < `SDR_NUM_CH; g++) begin : g_lane
      rx_lane i_rx_lane (
        .sys0_clk    (sys0_clk),
        .rst_i       (rst_i),
        .in_valid_i  (samples.valid),
        .in_sample_i (samples.ch[g]),
        .take_i      (lane_take[g]),
        .out_o       (lane_out[g]),
        .overflow_o  (overflow_o[g])
      );
    end
  endgenerate

  sample_packer i_sample_packer (
    .sys0_clk       (sys0_clk),
    .rst_i          (rst_i),
    .lanes_i        (lane_out),
    .take_o         (lane_take),
    .credit_i       (credit_i),
    .stream_valid_o (stream_valid_o),
    .stream_o       (stream_o)
  );

  adc_spi_ctrl i_adc_spi_ctrl (
    .sys0_clk    (sys0_clk),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .sclk_drv_o  (sclk_drv),
    .sclk_gate_o (sclk_gate),
    .sen_o       (sen),
    .mosi_o      (adc_smosi_o),
    .miso_i      (adc_smiso_i)
  );

  // board sclk forced high when gated or deselected
  assign adc_sclk_o = sclk_drv || !sclk_gate || sen;
  assign adc_sen_o  = sen;

endmodule

//--- tb_sdr_rx.sv
//////////////////////////////////////////////////
// directed tests on sdr_rx_top, both adc channels
// spi slave model answers from a 128 byte map
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sdr_rx_settings.svh"

module tb_sdr_rx;

  localparam int NCH      = `SDR_NUM_CH;
  localparam int DECIM    = 1 << `SDR_DECIM_LOG2;
  localparam int CLK_NS   = 4;
  localparam int FRAME    = 16 * 2 * `SDR_SPI_DIV + 2;  // cycles per spi command
  localparam int WAIT_MAX = 200;
  // resets, 148 fed blocks, idle waits, three spi frames, drain slack
  localparam int RUN_CYC  = 20 + 148 * (DECIM + 1) + 40 + 3 * FRAME + 200;

  logic                     sys0_clk;
  logic                     rst_i;
  logic                     capture_en_i;
  logic [13:0]              adc_da_i;
  logic [13:0]              adc_db_i;
  logic                     credit_i;
  logic                     stream_valid_o;
  sdr_rx_pkg::stream_word_t stream_o;
  logic [NCH-1:0]           overflow_o;
  logic                     cmd_valid_i;
  sdr_rx_pkg::spi_cmd_t     cmd_i;
  logic                     cmd_ready_o;
  logic                     rd_valid_o;
  logic [7:0]               rd_data_o;
  logic                     adc_sclk_o;
  logic                     adc_sen_o;
  logic                     adc_smosi_o;
  logic                     adc_smiso_i;

  sdr_rx_pkg::stream_word_t got_q [$];       // words seen on the stream
  sdr_rx_pkg::adc_word_t    exp_q [NCH][$];  // expected averages per lane
  logic [7:0]               slv_regs [128];  // adc register map
  logic [15:0]              slv_sr;          // slave shift register
  logic [7:0]               slv_hdr;         // r/w bit and address of this frame
  int                       slv_cnt;         // bits in this frame
  logic [15:0]              lfsr;
  logic [7:0]               rd_last;
  bit                       auto_credit;     // return a credit per word
  bit                       in_frame;        // a command owns the spi bus
  int                       kidx;
  int                       owed;
  int                       fill;
  int                       rd_seen;
  int                       word_errs;
  int                       byte_errs;
  int                       flag_errs;
  int                       other_errs;

  sdr_rx_top i_sdr_rx_top (.*);

  always #(CLK_NS / 2) sys0_clk = ~sys0_clk;

  // galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int known_sample(int idx);
    case (idx % 8)  // full scale ends and small negatives
      0:       return 8191;
      1:       return -8192;
      2:       return -1;
      3:       return -2;
      4:       return 3;
      5:       return 100;
      default: return -8192;
    endcase
  endfunction

  function automatic logic [13:0] to_raw(int v);
    return 14'(v + 8192);  // offset binary, midscale is zero
  endfunction

  function automatic int floor_avg(int sum);
    return (sum >= 0) ? sum / DECIM : -((-sum + DECIM - 1) / DECIM);  // toward minus inf
  endfunction

  function automatic logic [7:0] fill_byte(logic [6:0] a);
    return 8'({1'b0, a} * 8'd37 + 8'h5A);  // odd multiplier, every address bit counts
  endfunction

  // stream capture, buffer model, spi frame rules
  always @(negedge sys0_clk) begin
    if (!rst_i) begin
      if (stream_valid_o) begin
        got_q.push_back(stream_o);
        fill++;
        if (fill > `SDR_CREDITS) begin
          other_errs++;
          $display("buffer overrun at %0t ns, a word was sent without credit", $time);
        end
        if (auto_credit) begin
          owed++;
        end
      end
      if (rd_valid_o) begin
        rd_seen++;
        rd_last = rd_data_o;
      end
      if ((adc_sen_o && !adc_sclk_o) || (!adc_sen_o && !in_frame)) begin
        other_errs++;
        $display("adc_sen_o or adc_sclk_o wrong outside the spi frame at %0t ns", $time);
      end
    end
  end

  always @(posedge sys0_clk) begin
    if (!rst_i && owed > 0) begin  // drain one buffered word
      credit_i <= 1'b1;
      owed--;
      fill--;
    end else begin
      credit_i <= 1'b0;
    end
  end

  // spi slave, samples on rising sclk, drives read data on falling
  always @(negedge adc_sen_o) begin
    slv_cnt = 0;
  end

  always @(posedge adc_sclk_o) begin
    if (!adc_sen_o && slv_cnt < 16) begin  // the edge after bit 16 is ignored
      slv_sr = {slv_sr[14:0], adc_smosi_o};
      slv_cnt++;
      if (slv_cnt == 8) begin
        slv_hdr = slv_sr[7:0];  // r/w and address are in
      end
      if (slv_cnt == 16 && !slv_sr[15]) begin
        slv_regs[slv_sr[14:8]] = slv_sr[7:0];
      end
    end
  end

  always @(negedge adc_sclk_o) begin
    if (!adc_sen_o && slv_cnt >= 8 && slv_cnt < 16 && slv_hdr[7]) begin
      adc_smiso_i <= slv_regs[slv_hdr[6:0]][15 - slv_cnt];
    end
  end

  task automatic check_word(int idx, sdr_rx_pkg::stream_word_t got,
                            sdr_rx_pkg::stream_word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("error at %0t ns: word %0d ch %0d seq %0d sample %0d, expected %0d %0d %0d",
               $time, idx, got.ch, got.seq, got.sample, exp.ch, exp.seq, exp.sample);
    end
  endtask

  task automatic check_byte(logic [7:0] got, logic [7:0] exp, string what);
    if (got !== exp) begin
      byte_errs++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      flag_errs++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic reset_dut();
    @(posedge sys0_clk);
    rst_i        <= 1'b1;
    capture_en_i <= 1'b0;
    cmd_valid_i  <= 1'b0;
    auto_credit = 1'b0;
    owed        = 0;
    repeat (3) @(posedge sys0_clk);
    rst_i <= 1'b0;
    got_q.delete();
    for (int c = 0; c < NCH; c++) begin
      exp_q[c].delete();
    end
    fill    = 0;
    rd_seen = 0;
  endtask

  // n blocks of DECIM samples on both buses, averages queued as expected
  task automatic feed_blocks(int n, bit use_rand);
    int v [NCH];
    int sum [NCH];
    for (int b = 0; b < n; b++) begin
      sum = '{default: 0};
      for (int i = 0; i < DECIM; i++) begin
        for (int c = 0; c < NCH; c++) begin
          v[c]    = use_rand ? int'(rand_bits(14)) - 8192 : known_sample(kidx + 3 * c);
          sum[c] += v[c];
        end
        kidx++;
        @(posedge sys0_clk);
        capture_en_i <= 1'b1;
        adc_da_i     <= to_raw(v[0]);
        adc_db_i     <= to_raw(v[1]);
      end
      for (int c = 0; c < NCH; c++) begin
        exp_q[c].push_back(sdr_rx_pkg::adc_word_t'(floor_avg(sum[c])));
      end
    end
    @(posedge sys0_clk);
    capture_en_i <= 1'b0;
  endtask

  task automatic wait_words(int n);
    int cnt;
    cnt = 0;
    while (got_q.size() < n && cnt < WAIT_MAX) begin
      @(posedge sys0_clk);
      cnt++;
    end
    if (got_q.size() < n) begin
      other_errs++;
      $display("timed out waiting for %0d stream words, %0d came", n, got_q.size());
    end
  endtask

  task automatic expect_count(int n);
    repeat (10) @(posedge sys0_clk);  // nothing more may show up
    if (got_q.size() != n) begin
      other_errs++;
      $display("error at %0t ns: %0d words seen, expected %0d", $time, got_q.size(), n);
    end
  endtask

  // lanes alternate, seq counts from 0 since reset
  task automatic check_stream();
    sdr_rx_pkg::stream_word_t exp;
    int n;
    n = 0;
    for (int c = 0; c < NCH; c++) begin
      n += exp_q[c].size();
    end
    expect_count(n);
    for (int k = 0; k < n && k < got_q.size(); k++) begin
      exp.ch     = k % NCH;
      exp.seq    = 8'(k);
      exp.sample = exp_q[k % NCH][k / NCH];
      check_word(k, got_q[k], exp);
    end
  endtask

  task automatic give_credits(int n);
    @(negedge sys0_clk);
    owed += n;
  endtask

  task automatic spi_command(sdr_rx_pkg::spi_op_e op, logic [6:0] addr, logic [7:0] data);
    sdr_rx_pkg::spi_cmd_t cmd;
    int cnt;
    cmd.op   = op;
    cmd.addr = {1'b0, addr};
    cmd.data = data;
    @(posedge sys0_clk);
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    @(negedge sys0_clk);  // ready is high in idle, handshake on next edge
    @(posedge sys0_clk);
    cmd_valid_i <= 1'b0;
    in_frame = 1'b1;
    cnt = 0;
    @(negedge sys0_clk);
    while (!adc_sen_o && cnt < 2 * FRAME) begin
      if (cmd_ready_o) begin
        other_errs++;
        $display("cmd_ready_o went high in the middle of the spi frame at %0t ns", $time);
      end
      cnt++;
      @(negedge sys0_clk);
    end
    in_frame = 1'b0;
    // sen drops on the handshake edge, one cycle short of the frame
    if (cnt != FRAME - 1 || !cmd_ready_o || slv_cnt != 16) begin
      other_errs++;
      $display("spi frame wrong, adc_sen_o low for %0d cycles, slave saw %0d bits",
               cnt, slv_cnt);
    end
  endtask

  task automatic test_decimation();
    reset_dut();
    auto_credit = 1'b1;
    feed_blocks(4, 1'b0);
    feed_blocks(4, 1'b1);
    wait_words(8 * NCH);
    check_stream();
  endtask

  task automatic test_round_robin();
    reset_dut();
    auto_credit = 1'b1;
    feed_blocks(130, 1'b1);  // 260 words, seq wraps once
    wait_words(130 * NCH);
    check_stream();
  endtask

  task automatic test_credit_limit();
    reset_dut();
    feed_blocks(3, 1'b1);    // third block stays in the lanes
    wait_words(`SDR_CREDITS);
    expect_count(`SDR_CREDITS);
    for (int k = 1; k <= NCH; k++) begin
      give_credits(1);
      wait_words(`SDR_CREDITS + k);
      expect_count(`SDR_CREDITS + k);
    end
    @(negedge sys0_clk);
    for (int c = 0; c < NCH; c++) begin
      check_flag(overflow_o[c], 1'b0, $sformatf("overflow lane %0d", c));
    end
    check_stream();
  endtask

  task automatic test_overflow();
    reset_dut();
    feed_blocks(5, 1'b1);    // blocks 4 and 5 hit full lanes
    wait_words(2 * NCH);
    for (int c = 0; c < NCH; c++) begin
      exp_q[c].delete(4);
      exp_q[c].delete(3);
    end
    @(negedge sys0_clk);
    for (int c = 0; c < NCH; c++) begin
      check_flag(overflow_o[c], 1'b1, $sformatf("overflow lane %0d", c));
    end
    give_credits(`SDR_CREDITS);
    wait_words(3 * NCH);
    auto_credit = 1'b1;
    feed_blocks(2, 1'b1);
    wait_words(5 * NCH);
    @(negedge sys0_clk);
    for (int c = 0; c < NCH; c++) begin
      check_flag(overflow_o[c], 1'b1, $sformatf("overflow lane %0d after resume", c));
    end
    check_stream();
  endtask

  task automatic test_spi();
    reset_dut();
    spi_command(sdr_rx_pkg::SPI_WRITE, 7'h15, 8'h3C);
    check_byte(slv_regs[7'h15], 8'h3C, "slave register 15h");
    spi_command(sdr_rx_pkg::SPI_READ, 7'h15, 8'h00);
    check_byte(rd_last, 8'h3C, "read back of 15h");
    spi_command(sdr_rx_pkg::SPI_READ, 7'h6B, 8'hFF);
    check_byte(rd_last, fill_byte(7'h6B), "read of untouched 6Bh");
    if (rd_seen != 2) begin
      other_errs++;
      $display("rd_valid_o pulsed %0d times over one write and two reads", rd_seen);
    end
  endtask

  initial begin
    #(RUN_CYC * 4 * CLK_NS);
    $display("watchdog expired at %0t ns, tests did not finish", $time);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    sys0_clk     = 1'b0;
    rst_i        = 1'b1;
    capture_en_i = 1'b0;
    adc_da_i     = '0;
    adc_db_i     = '0;
    credit_i     = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    adc_smiso_i  = 1'b0;
    lfsr         = 16'd68;
    {kidx, owed, fill, rd_seen, slv_cnt} = '0;
    {word_errs, byte_errs, flag_errs, other_errs} = '0;
    for (int a = 0; a < 128; a++) begin
      slv_regs[a] = fill_byte(7'(a));
    end
    test_decimation();
    test_round_robin();
    test_credit_limit();
    test_overflow();
    test_spi();
    $display("errors: %0d word, %0d byte, %0d flag, %0d other",
             word_errs, byte_errs, flag_errs, other_errs);
    if (word_errs + byte_errs + flag_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
sdr_rx_pkg.sv
adc_capture.sv
rx_lane.sv
sample_packer.sv
adc_spi_ctrl.sv
sdr_rx_top.sv
tb_sdr_rx.sv

//--- Bender.yml
package:
  name: sdr_rx

sources:
  - include_dirs:
      - .
    files:
      - sdr_rx_pkg.sv
      - adc_capture.sv
      - rx_lane.sv
      - sample_packer.sv
      - adc_spi_ctrl.sv
      - sdr_rx_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_sdr_rx.sv
